// File: sim.f
+incdir+source
source/sram_cmd_pkg.sv
source/sram_bus_pkg.sv
source/sram_word_port.sv
source/crc32_engine.sv
source/sram_cmd_seq.sv
source/sram_ctrl_top.sv
sim/tb_checker.sv
sim/tb_top.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
verilator --binary --timing --top-module tb_top -f sim.f -o tb_sim || exit 1
out=$(./obj_dir/tb_sim)
echo "$out"
echo "$out" | grep -qx "Result: PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// File: sim/tb_top.sv
/*
 * Testbench top. Makes clock and reset, drives seeded random commands
 * on the falling edge and models a 16-bit SRAM with random ready delay.
 * The checker next to the DUT does all comparing.
 */
`default_nettype none

module tb_top
    import sram_cmd_pkg::*;
    import sram_bus_pkg::*;
();

    localparam int NUM_CMDS    = 200;
    localparam int MEM_WORDS   = 512;
    // Worst case of 8 words per command at 20 cycles per word
    localparam int CYCLE_LIMIT = NUM_CMDS * 8 * 20;

    logic       clk;
    logic       resetn;
    logic       start;
    cmd_t       cmd;
    byte_addr_t addr_in;
    word_t      data_in;
    strb_t      wstrb;
    logic       busy;
    logic       done;
    word_t      result;
    logic       sram_valid;
    logic       sram_ready = 1'b0;
    logic       sram_we;
    half_addr_t sram_addr;
    half_t      sram_wdata;
    half_t      sram_rdata = '0;

    word_t  preload [MEM_WORDS];
    half_t  sram_mem [2*MEM_WORDS];
    integer seed = 19910;
    int     wait_cnt;
    int     cycles = 0;
    int     value_errors;
    int     protocol_errors;
    int     cmds_done;

    sram_ctrl_top u_dut (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .cmd        (cmd),
        .addr_in    (addr_in),
        .data_in    (data_in),
        .wstrb      (wstrb),
        .busy       (busy),
        .done       (done),
        .result     (result),
        .sram_valid (sram_valid),
        .sram_ready (sram_ready),
        .sram_we    (sram_we),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata)
    );

    tb_checker #(
        .MEM_WORDS (MEM_WORDS)
    ) u_chk (
        .clk             (clk),
        .resetn          (resetn),
        .start           (start),
        .cmd             (cmd),
        .addr_in         (addr_in),
        .data_in         (data_in),
        .wstrb           (wstrb),
        .busy            (busy),
        .done            (done),
        .result          (result),
        .sram_valid      (sram_valid),
        .sram_ready      (sram_ready),
        .sram_we         (sram_we),
        .sram_addr       (sram_addr),
        .sram_wdata      (sram_wdata),
        .preload         (preload),
        .value_errors    (value_errors),
        .protocol_errors (protocol_errors),
        .cmds_done       (cmds_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ====================
    // SRAM model
    // ====================
    // Writes land and the next ready delay is drawn at the handshake edge
    always @(posedge clk) begin
        if (!resetn) begin
            wait_cnt = 0;
            for (int i = 0; i < MEM_WORDS; i++) begin
                sram_mem[2*i]   = preload[i][15:0];
                sram_mem[2*i+1] = preload[i][31:16];
            end
        end else if (sram_valid && sram_ready) begin
            if (sram_we) begin
                sram_mem[sram_addr[9:0]] = sram_wdata;
            end
            wait_cnt = $random(seed) & 3;
        end
    end

    always @(negedge clk) begin
        if (!resetn) begin
            sram_ready = 1'b0;
        end else if (sram_valid && !sram_ready) begin
            if (wait_cnt == 0) begin
                sram_ready = 1'b1;
                sram_rdata = sram_mem[sram_addr[9:0]];
            end else begin
                wait_cnt = wait_cnt - 1;
            end
        end else begin
            sram_ready = 1'b0;
        end
    end

    // ====================
    // Stimulus
    // ====================
    task automatic drive_random_command();
        word_t rnd;
        word_t pick;
        rnd     = $random(seed);
        pick    = $random(seed);
        addr_in = {22'd0, rnd[7:0], 2'b00};
        data_in = $random(seed);
        wstrb   = 4'hF;
        case (pick[2:0])
            3'd0, 3'd1: cmd = CMD_READ;
            3'd2, 3'd3: cmd = CMD_WRITE;
            3'd4: begin
                cmd   = CMD_WRITE;
                wstrb = rnd[11:8];
            end
            3'd5, 3'd6: begin
                cmd = CMD_CRC;
                // Now and then an end address at or below the start
                if (pick[5:3] == 3'd0) begin
                    data_in = addr_in & rnd;
                end else begin
                    data_in = addr_in + {27'd0, pick[8:6], 2'b00} + 32'd4;
                end
            end
            default: cmd = cmd_t'({rnd[15:12], 4'h8});
        endcase
        start = 1'b1;
    endtask

    // A stray full write that must not be accepted
    task automatic poke_start_while_busy();
        word_t rnd;
        rnd = $random(seed);
        if (rnd[3:0] == 4'd0) begin
            cmd     = CMD_WRITE;
            addr_in = {22'd0, rnd[15:8], 2'b00};
            data_in = ~rnd;
            wstrb   = 4'hF;
            start   = 1'b1;
        end
    endtask

    initial begin
        resetn  = 1'b0;
        start   = 1'b0;
        cmd     = CMD_READ;
        addr_in = '0;
        data_in = '0;
        wstrb   = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            preload[i] = $random(seed);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        for (int n = 0; n < NUM_CMDS; n++) begin
            drive_random_command();
            @(negedge clk);
            start = 1'b0;
            while (!done) begin
                poke_start_while_busy();
                @(negedge clk);
                start = 1'b0;
            end
        end

        repeat (4) @(negedge clk);
        if (cmds_done != NUM_CMDS) begin
            $display("Only %0d of %0d commands completed", cmds_done, NUM_CMDS);
        end
        $display("Commands checked: %0d, value errors: %0d, protocol errors: %0d",
                 cmds_done, value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0 && cmds_done == NUM_CMDS) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Result: FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_checker.sv
/*
 * Watches the DUT command and SRAM ports. Keeps a word model of the
 * memory, predicts every result and checks the handshakes.
 * Error counts go back to the testbench top.
 */
`default_nettype none

`include "sram_ctrl_cfg.svh"

module tb_checker
    import sram_cmd_pkg::*;
    import sram_bus_pkg::*;
#(
    parameter int MEM_WORDS = 512
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       start,
    input  cmd_t       cmd,
    input  byte_addr_t addr_in,
    input  word_t      data_in,
    input  strb_t      wstrb,
    input  logic       busy,
    input  logic       done,
    input  word_t      result,
    input  logic       sram_valid,
    input  logic       sram_ready,
    input  logic       sram_we,
    input  half_addr_t sram_addr,
    input  half_t      sram_wdata,
    input  word_t      preload [MEM_WORDS],
    output int         value_errors,
    output int         protocol_errors,
    output int         cmds_done
);

    word_t      model [MEM_WORDS];
    logic       first_sample;
    logic       active;
    logic       act_unknown;
    string      act_name;
    word_t      exp_result;
    word_t      last_result;
    int         valid_seen;
    int         low_run;
    logic       prev_valid;
    logic       prev_ready;
    logic       prev_we;
    half_addr_t prev_addr;
    half_t      prev_wdata;

    // Byte-wise CRC-32, bytes of each word in little-endian order
    function automatic word_t crc_add_word(input word_t crc, input word_t w);
        word_t c;
        c = crc;
        for (int k = 0; k < 4; k++) begin
            c = c ^ {24'd0, w[8*k +: 8]};
            for (int j = 0; j < 8; j++) begin
                c = c[0] ? ((c >> 1) ^ `CRC32_POLY) : (c >> 1);
            end
        end
        return c;
    endfunction

    // At least one word, then on while the next address is below the end
    function automatic word_t range_crc(input byte_addr_t first, input byte_addr_t stop);
        byte_addr_t a;
        word_t      c;
        a = first;
        c = crc_add_word(`CRC32_INIT, model[a[10:2]]);
        while (a + 32'd4 < stop) begin
            a = a + 32'd4;
            c = crc_add_word(c, model[a[10:2]]);
        end
        return ~c;
    endfunction

    task automatic report_protocol_fault(input string what);
        protocol_errors = protocol_errors + 1;
        $display("Protocol error at time %0t: %s", $time, what);
    endtask

    task automatic check_sram_bus();
        if (prev_valid && !prev_ready) begin
            if (!sram_valid || sram_addr !== prev_addr || sram_we !== prev_we ||
                sram_wdata !== prev_wdata) begin
                report_protocol_fault("SRAM request changed while waiting for ready");
            end
        end
        if (prev_valid && prev_ready && sram_valid) begin
            report_protocol_fault("sram_valid stayed high after a handshake");
        end
        if (sram_valid && !prev_valid && low_run < 1) begin
            report_protocol_fault("sram_valid gap between transactions too short");
        end
        if (sram_valid) begin
            low_run = 0;
            valid_seen = valid_seen + 1;
            if (!active) begin
                report_protocol_fault("SRAM access with no command in progress");
            end
        end else begin
            low_run = low_run + 1;
        end
        prev_valid = sram_valid;
        prev_ready = sram_ready;
        prev_we    = sram_we;
        prev_addr  = sram_addr;
        prev_wdata = sram_wdata;
    endtask

    task automatic finish_command();
        if (!active) begin
            report_protocol_fault("done pulsed with no command in progress");
        end else begin
            if (busy !== 1'b0) begin
                report_protocol_fault("busy still high at done");
            end
            if (act_unknown && valid_seen != 0) begin
                report_protocol_fault("SRAM accessed during an unknown command");
            end
            if (result !== exp_result) begin
                value_errors = value_errors + 1;
                $display("FAILED at time %0t: %s result %h, expected %h",
                         $time, act_name, result, exp_result);
            end
            last_result = exp_result;
            cmds_done   = cmds_done + 1;
            active      = 1'b0;
        end
    endtask

    // Model memory moves on at acceptance, commands never overlap
    task automatic accept_command();
        logic [8:0] idx;
        idx         = addr_in[10:2];
        active      = 1'b1;
        act_unknown = 1'b0;
        valid_seen  = 0;
        case (cmd)
            CMD_READ: begin
                act_name   = "read";
                exp_result = model[idx];
            end
            CMD_WRITE: begin
                act_name = "write";
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) begin
                        model[idx][8*b +: 8] = data_in[8*b +: 8];
                    end
                end
                exp_result = '0;
            end
            CMD_CRC: begin
                act_name   = "crc";
                exp_result = range_crc(addr_in, data_in);
            end
            default: begin
                act_name    = "unknown command";
                act_unknown = 1'b1;
                exp_result  = last_result;
            end
        endcase
    endtask

    // ====================
    // Sampling
    // ====================
    always @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                model[i] = preload[i];
            end
            first_sample    = 1'b1;
            active          = 1'b0;
            valid_seen      = 0;
            low_run         = 2;
            prev_valid      = 1'b0;
            prev_ready      = 1'b0;
            value_errors    = 0;
            protocol_errors = 0;
            cmds_done       = 0;
        end else begin
            if (first_sample) begin
                if (busy !== 1'b0 || done !== 1'b0 || sram_valid !== 1'b0 ||
                    sram_we !== 1'b0) begin
                    report_protocol_fault("control outputs not low after reset");
                end
                last_result  = result;
                first_sample = 1'b0;
            end
            check_sram_bus();
            if (done) begin
                finish_command();
            end else if (active && busy !== 1'b1) begin
                report_protocol_fault("busy low while a command is in progress");
            end
            if (start && !busy) begin
                accept_command();
            end
        end
    end

endmodule

`default_nettype wire

// File: source/sram_ctrl_top.sv
/*
 * SRAM command processor top level. Connects the command sequencer,
 * the halfword-pair word port and the CRC-32 register.
 */
`default_nettype none

module sram_ctrl_top
    import sram_cmd_pkg::*;
    import sram_bus_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,

    // Command side
    input  logic       start,
    input  cmd_t       cmd,
    input  byte_addr_t addr_in,
    input  word_t      data_in,
    input  strb_t      wstrb,
    output logic       busy,
    output logic       done,
    output word_t      result,

    // SRAM driver side
    output logic       sram_valid,
    input  logic       sram_ready,
    output logic       sram_we,
    output half_addr_t sram_addr,
    output half_t      sram_wdata,
    input  half_t      sram_rdata
);

    // Sequencer to word port
    logic       xfer_req;
    logic       xfer_we;
    byte_addr_t xfer_addr;
    word_t      xfer_wdata;
    logic       xfer_done;
    word_t      xfer_rdata;

    // Sequencer to CRC register
    logic  crc_init;
    logic  crc_update;
    word_t crc_data;
    word_t crc_value;

    sram_cmd_seq u_seq (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .cmd        (cmd),
        .addr_in    (addr_in),
        .data_in    (data_in),
        .wstrb      (wstrb),
        .busy       (busy),
        .done       (done),
        .result     (result),
        .xfer_req   (xfer_req),
        .xfer_we    (xfer_we),
        .xfer_addr  (xfer_addr),
        .xfer_wdata (xfer_wdata),
        .xfer_done  (xfer_done),
        .xfer_rdata (xfer_rdata),
        .crc_init   (crc_init),
        .crc_update (crc_update),
        .crc_data   (crc_data),
        .crc_value  (crc_value)
    );

    sram_word_port u_port (
        .clk        (clk),
        .resetn     (resetn),
        .xfer_req   (xfer_req),
        .xfer_we    (xfer_we),
        .xfer_addr  (xfer_addr),
        .xfer_wdata (xfer_wdata),
        .xfer_done  (xfer_done),
        .xfer_rdata (xfer_rdata),
        .sram_valid (sram_valid),
        .sram_ready (sram_ready),
        .sram_we    (sram_we),
        .sram_addr  (sram_addr),
        .sram_wdata (sram_wdata),
        .sram_rdata (sram_rdata)
    );

    crc32_engine u_crc (
        .clk        (clk),
        .resetn     (resetn),
        .crc_init   (crc_init),
        .crc_update (crc_update),
        .crc_data   (crc_data),
        .crc_value  (crc_value)
    );

endmodule

`default_nettype wire

// File: source/sram_cmd_seq.sv
/*
 * Command sequencer. Accepts a command on start, drives word transfers
 * through the word port and the CRC register, and ends each command
 * with a one-cycle done pulse and a new result.
 */
`default_nettype none

module sram_cmd_seq
    import sram_cmd_pkg::*;
    import sram_bus_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,

    // Command side
    input  logic       start,
    input  cmd_t       cmd,
    input  byte_addr_t addr_in,
    input  word_t      data_in,
    input  strb_t      wstrb,
    output logic       busy,
    output logic       done,
    output word_t      result,

    // Word port
    output logic       xfer_req,
    output logic       xfer_we,
    output byte_addr_t xfer_addr,
    output word_t      xfer_wdata,
    input  logic       xfer_done,
    input  word_t      xfer_rdata,

    // CRC register
    output logic       crc_init,
    output logic       crc_update,
    output word_t      crc_data,
    input  word_t      crc_value
);

    seq_state_t state;

    // Latched command. cur_data holds the end address for CRC
    byte_addr_t cur_addr;
    word_t      cur_data;
    strb_t      cur_strb;

    word_t               merged;
    logic [$bits(cur_addr):0] next_addr_ext;
    logic                last_word;

    // New bytes where the strobe is set, old bytes elsewhere
    always_comb begin
        for (int i = 0; i < $bits(strb_t); i++) begin
            merged[8*i +: 8] = cur_strb[i] ? cur_data[8*i +: 8] : xfer_rdata[8*i +: 8];
        end
    end

    // Extra bit so the range check does not wrap
    assign next_addr_ext = {1'b0, cur_addr} + 4;
    assign last_word     = next_addr_ext >= {1'b0, cur_data};

    assign xfer_addr  = cur_addr;
    assign xfer_wdata = cur_data;
    assign xfer_we    = (state == SEQ_WRITE);

    // Fold each CRC word on the cycle it arrives
    assign crc_update = (state == SEQ_CRC_READ) && xfer_done;
    assign crc_data   = xfer_rdata;

    // ====================
    // Sequencer FSM
    // ====================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= SEQ_IDLE;
            busy     <= 1'b0;
            done     <= 1'b0;
            xfer_req <= 1'b0;
            crc_init <= 1'b0;
            result   <= '0;
        end else begin
            done     <= 1'b0;
            xfer_req <= 1'b0;
            crc_init <= 1'b0;

            case (state)
                SEQ_IDLE: begin
                    if (start && !busy) begin
                        busy     <= 1'b1;
                        cur_addr <= addr_in;
                        cur_data <= data_in;
                        cur_strb <= wstrb;
                        case (cmd)
                            CMD_READ: begin
                                xfer_req <= 1'b1;
                                state    <= SEQ_READ;
                            end
                            CMD_WRITE: begin
                                xfer_req <= 1'b1;
                                // Partial strobes need the old word first
                                state    <= (wstrb == '1) ? SEQ_WRITE : SEQ_RMW_READ;
                            end
                            CMD_CRC: begin
                                crc_init <= 1'b1;
                                xfer_req <= 1'b1;
                                state    <= SEQ_CRC_READ;
                            end
                            default: state <= SEQ_DONE;
                        endcase
                    end
                end

                SEQ_READ: begin
                    if (xfer_done) begin
                        result <= xfer_rdata;
                        done   <= 1'b1;
                        busy   <= 1'b0;
                        state  <= SEQ_IDLE;
                    end
                end

                SEQ_RMW_READ: begin
                    if (xfer_done) begin
                        cur_data <= merged;
                        xfer_req <= 1'b1;
                        state    <= SEQ_WRITE;
                    end
                end

                SEQ_WRITE: begin
                    if (xfer_done) begin
                        result <= '0;
                        done   <= 1'b1;
                        busy   <= 1'b0;
                        state  <= SEQ_IDLE;
                    end
                end

                SEQ_CRC_READ: begin
                    if (xfer_done) begin
                        if (last_word) begin
                            state <= SEQ_CRC_END;
                        end else begin
                            cur_addr <= next_addr_ext[$bits(cur_addr)-1:0];
                            xfer_req <= 1'b1;
                        end
                    end
                end

                // Last fold has landed in crc_value
                SEQ_CRC_END: begin
                    result <= ~crc_value;
                    done   <= 1'b1;
                    busy   <= 1'b0;
                    state  <= SEQ_IDLE;
                end

                // Unknown code, result untouched
                SEQ_DONE: begin
                    done  <= 1'b1;
                    busy  <= 1'b0;
                    state <= SEQ_IDLE;
                end

                default: begin
                    busy  <= 1'b0;
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/crc32_engine.sv
/*
 * Running CRC-32 register, reflected Ethernet polynomial.
 * crc_init reloads all ones; crc_update folds one 32-bit word,
 * lowest bit first, in a single cycle. Output is not inverted.
 */
`default_nettype none

`include "sram_ctrl_cfg.svh"

module crc32_engine
    import sram_bus_pkg::*;
(
    input  logic  clk,
    input  logic  resetn,
    input  logic  crc_init,
    input  logic  crc_update,
    input  word_t crc_data,
    output word_t crc_value
);

    // Bitwise fold, 32 iterations unrolled by synthesis
    function automatic word_t crc32_fold(input word_t crc, input word_t data);
        word_t c;
        c = crc;
        for (int i = 0; i < `DATA_W; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ `CRC32_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crc_value <= `CRC32_INIT;
        end else if (crc_init) begin
            crc_value <= `CRC32_INIT;
        end else if (crc_update) begin
            crc_value <= crc32_fold(crc_value, crc_data);
        end
    end

endmodule

`default_nettype wire

// File: source/sram_word_port.sv
/*
 * Runs one 32-bit transfer as two valid/ready halfword transactions,
 * low half first. Owns all SRAM handshake timing: holding during
 * back-pressure and the idle gap between the two halves.
 */
`default_nettype none

`include "sram_ctrl_cfg.svh"

module sram_word_port
    import sram_bus_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,

    // Transfer request from the sequencer
    input  logic       xfer_req,
    input  logic       xfer_we,
    input  byte_addr_t xfer_addr,
    input  word_t      xfer_wdata,
    output logic       xfer_done,
    output word_t      xfer_rdata,

    // SRAM driver side
    output logic       sram_valid,
    input  logic       sram_ready,
    output logic       sram_we,
    output half_addr_t sram_addr,
    output half_t      sram_wdata,
    input  half_t      sram_rdata
);

    typedef enum logic [2:0] {
        P_IDLE,
        P_LOW,
        P_GAP,
        P_SETUP,
        P_HIGH
    } port_state_t;

    port_state_t state;

    // Upper write half waits here while the low half is out
    half_t hi_wdata;
    // Low read half, kept until the word is assembled
    half_t low_half;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state      <= P_IDLE;
            sram_valid <= 1'b0;
            sram_we    <= 1'b0;
            xfer_done  <= 1'b0;
        end else begin
            xfer_done <= 1'b0;

            case (state)
                P_IDLE: begin
                    if (xfer_req) begin
                        sram_addr  <= xfer_addr[`SRAM_ADDR_W:1];
                        sram_wdata <= xfer_wdata[`HALF_W-1:0];
                        hi_wdata   <= xfer_wdata[`DATA_W-1:`HALF_W];
                        sram_we    <= xfer_we;
                        sram_valid <= 1'b1;
                        state      <= P_LOW;
                    end
                end

                // Everything held until ready
                P_LOW: begin
                    if (sram_ready) begin
                        low_half   <= sram_rdata;
                        sram_valid <= 1'b0;
                        state      <= P_GAP;
                    end
                end

                // valid low here, move to the upper halfword
                P_GAP: begin
                    sram_addr  <= sram_addr + 1'b1;
                    sram_wdata <= hi_wdata;
                    state      <= P_SETUP;
                end

                // Second low cycle before the next valid
                P_SETUP: begin
                    sram_valid <= 1'b1;
                    state      <= P_HIGH;
                end

                P_HIGH: begin
                    if (sram_ready) begin
                        xfer_rdata <= {sram_rdata, low_half};
                        xfer_done  <= 1'b1;
                        sram_valid <= 1'b0;
                        sram_we    <= 1'b0;
                        state      <= P_IDLE;
                    end
                end

                default: begin
                    sram_valid <= 1'b0;
                    sram_we    <= 1'b0;
                    state      <= P_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: source/sram_bus_pkg.sv
/*
 * Data and address types for the memory side of the controller.
 * Shared by the word port, the sequencer, the top level and the checker.
 */
`default_nettype none

`include "sram_ctrl_cfg.svh"

package sram_bus_pkg;

    // Command data word and byte address
    typedef logic [`DATA_W-1:0] word_t;
    typedef logic [`DATA_W-1:0] byte_addr_t;

    // SRAM data and halfword address
    typedef logic [`HALF_W-1:0]      half_t;
    typedef logic [`SRAM_ADDR_W-1:0] half_addr_t;

    // Byte lane strobes, bit n selects byte n
    typedef logic [`DATA_W/8-1:0] strb_t;

endpackage

`default_nettype wire

// File: source/sram_cmd_pkg.sv
/*
 * Command-side types: the command code and the sequencer state.
 * Used by the sequencer, the top level and the testbench.
 */
`default_nettype none

`include "sram_ctrl_cfg.svh"

package sram_cmd_pkg;

    // Command code, other values are legal and treated as unknown
    typedef enum logic [7:0] {
        CMD_READ  = `CMD_READ_CODE,
        CMD_WRITE = `CMD_WRITE_CODE,
        CMD_CRC   = `CMD_CRC_CODE
    } cmd_t;

    // Sequencer states
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_READ,
        SEQ_WRITE,
        SEQ_RMW_READ,
        SEQ_CRC_READ,
        SEQ_CRC_END,
        SEQ_DONE
    } seq_state_t;

endpackage

`default_nettype wire

// File: source/sram_ctrl_cfg.svh
/*
 * Build constants for the SRAM command processor.
 * Included by the packages and by any module that slices SRAM addresses
 * or needs the CRC-32 constants.
 */
`ifndef SRAM_CTRL_CFG_SVH
`define SRAM_CTRL_CFG_SVH

// ====================
// Widths
// ====================
`define DATA_W       32
`define HALF_W       16
// Halfword address, byte-address bits 18:1
`define SRAM_ADDR_W  18

// ====================
// CRC-32, reflected Ethernet form
// ====================
`define CRC32_POLY   32'hEDB88320
`define CRC32_INIT   32'hFFFFFFFF

// Command codes
`define CMD_READ_CODE   8'h01
`define CMD_WRITE_CODE  8'h02
`define CMD_CRC_CODE    8'h04

`endif
